// ==== include/stream_consts.svh ====
`ifndef STREAM_CONSTS_SVH
`define STREAM_CONSTS_SVH

// stream side widths.
`define STREAM_DATA_W 32
`define STREAM_STRB_W (`STREAM_DATA_W / 8)

// host side field widths.
`define BURST_LEN_W 8
`define DELAY_W 8
`define BURST_CNT_W 16

`endif

// ==== design/axis_pkg.sv ====
`include "stream_consts.svh"

package axis_pkg;

  // ********************
  // one beat on the master stream port.
  typedef struct packed {
    logic [`STREAM_DATA_W-1:0] data;
    logic [`STREAM_STRB_W-1:0] strb;
    logic                      last;
  } axis_beat_t;

  // ********************
  // burst generator states.
  typedef enum logic [1:0] {
    IDLE         = 2'b00,
    INIT_COUNTER = 2'b01,
    SEND_STREAM  = 2'b10
  } gen_state_e;

endpackage

// ==== design/gen_cfg_pkg.sv ====
`include "stream_consts.svh"

package gen_cfg_pkg;

  // ********************
  // register map, base reads back the burst count.
  typedef enum logic [1:0] {
    REG_CTRL  = 2'd0,
    REG_DELAY = 2'd1,
    REG_LEN   = 2'd2,
    REG_BASE  = 2'd3
  } reg_addr_e;

  // configuration levels seen by the generator.
  typedef struct packed {
    logic                      enable;
    logic [`DELAY_W-1:0]       start_delay;
    logic [`BURST_LEN_W-1:0]   burst_len;
    logic [`STREAM_DATA_W-1:0] base;
  } gen_cfg_t;

  // one host access, single cycle strobes.
  typedef struct packed {
    logic        wr;
    logic        rd;
    reg_addr_e   addr;
    logic [31:0] wdata;
  } host_req_t;

endpackage

// ==== design/pattern_regs.sv ====
`include "stream_consts.svh"

module pattern_regs (
  input  logic                   M_AXIS_ACLK,
  input  logic                   M_AXIS_ARESETN,
  input  gen_cfg_pkg::host_req_t host_req,
  output logic [31:0]            rdata,
  output logic                   rvalid,
  input  logic                   burst_done,
  output gen_cfg_pkg::gen_cfg_t  cfg
);
  import gen_cfg_pkg::*;

  gen_cfg_t                cfg_q;
  logic [`BURST_CNT_W-1:0] burst_cnt;
  logic [31:0]             rd_mux;

  assign cfg = cfg_q;

  // ********************
  // host writes.
  always_ff @(posedge M_AXIS_ACLK) begin
    if (!M_AXIS_ARESETN) begin
      cfg_q <= '0;
    end else if (host_req.wr) begin
      case (host_req.addr)
        REG_CTRL:  cfg_q.enable      <= host_req.wdata[0];
        REG_DELAY: cfg_q.start_delay <= host_req.wdata[`DELAY_W-1:0];
        REG_LEN:   cfg_q.burst_len   <= host_req.wdata[`BURST_LEN_W-1:0];
        REG_BASE:  cfg_q.base        <= host_req.wdata[`STREAM_DATA_W-1:0];
        default:   cfg_q             <= cfg_q;
      endcase
    end
  end

  // completed bursts wrap at full count.
  always_ff @(posedge M_AXIS_ACLK) begin
    if (!M_AXIS_ARESETN) begin
      burst_cnt <= '0;
    end else if (burst_done) begin
      burst_cnt <= burst_cnt + 1'b1;
    end
  end

  // ********************
  // host reads.
  always_comb begin
    rd_mux = '0;
    case (host_req.addr)
      REG_CTRL:  rd_mux[0]                 = cfg_q.enable;
      REG_DELAY: rd_mux[`DELAY_W-1:0]      = cfg_q.start_delay;
      REG_LEN:   rd_mux[`BURST_LEN_W-1:0]  = cfg_q.burst_len;
      REG_BASE:  rd_mux[`BURST_CNT_W-1:0]  = burst_cnt;
      default:   rd_mux                    = '0;
    endcase
  end

  always_ff @(posedge M_AXIS_ACLK) begin
    if (!M_AXIS_ARESETN) begin
      rvalid <= 1'b0;
    end else begin
      rvalid <= host_req.rd;
    end
  end

  // read data is captured on the read strobe.
  always_ff @(posedge M_AXIS_ACLK) begin
    if (host_req.rd) begin
      rdata <= rd_mux;
    end
  end

  // host must not mix strobes.
  a_no_wr_rd: assert property (@(posedge M_AXIS_ACLK) disable iff (!M_AXIS_ARESETN)
    !(host_req.wr && host_req.rd))
    else $error("pattern_regs: wr and rd high in the same cycle");

endmodule

// ==== design/axis_burst_gen.sv ====
`include "stream_consts.svh"

module axis_burst_gen (
  input  logic                        M_AXIS_ACLK,
  input  logic                        M_AXIS_ARESETN,
  input  gen_cfg_pkg::gen_cfg_t       cfg,
  output logic                        burst_done,
  output logic                        M_AXIS_TVALID,
  output logic [`STREAM_DATA_W-1:0]   M_AXIS_TDATA,
  output logic [`STREAM_STRB_W-1:0]   M_AXIS_TSTRB,
  output logic                        M_AXIS_TLAST,
  input  logic                        M_AXIS_TREADY
);
  import axis_pkg::*;

  gen_state_e                state_q;
  logic [`DELAY_W-1:0]       delay_cnt;
  logic [`BURST_LEN_W-1:0]   beat_idx;
  logic [`BURST_LEN_W-1:0]   len_q;
  logic [`BURST_LEN_W-1:0]   last_idx;
  logic [`STREAM_DATA_W-1:0] base_q;
  axis_beat_t                beat_q;
  axis_beat_t                next_beat;
  logic                      tvalid_q;
  logic                      accept;
  logic                      load;

  // ********************
  // beat bookkeeping.
  // a length of zero still sends one beat.
  assign last_idx = (len_q == '0) ? '0 : len_q - 1'b1;

  assign accept     = tvalid_q && M_AXIS_TREADY;
  assign burst_done = accept && beat_q.last;

  // refill when empty or drained, never past the last beat.
  assign load = (state_q == SEND_STREAM) && !(tvalid_q && beat_q.last) &&
                (!tvalid_q || M_AXIS_TREADY);

  always_comb begin
    next_beat.data = base_q + `STREAM_DATA_W'(beat_idx);
    next_beat.strb = '1;
    next_beat.last = (beat_idx == last_idx);
  end

  // ********************
  // state machine.
  always_ff @(posedge M_AXIS_ACLK) begin
    if (!M_AXIS_ARESETN) begin
      state_q   <= IDLE;
      delay_cnt <= '0;
      beat_idx  <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          delay_cnt <= cfg.start_delay;
          if (cfg.enable) begin
            state_q <= INIT_COUNTER;
          end
        end
        INIT_COUNTER: begin
          beat_idx <= '0;
          if (delay_cnt == '0) begin
            state_q <= SEND_STREAM;
          end else begin
            delay_cnt <= delay_cnt - 1'b1;
          end
        end
        SEND_STREAM: begin
          if (load) begin
            beat_idx <= beat_idx + 1'b1;
          end
          if (burst_done) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // burst shape is frozen before sending starts.
  always_ff @(posedge M_AXIS_ACLK) begin
    if (state_q == INIT_COUNTER) begin
      len_q  <= cfg.burst_len;
      base_q <= cfg.base;
    end
  end

  // ********************
  // registered output stage.
  always_ff @(posedge M_AXIS_ACLK) begin
    if (!M_AXIS_ARESETN) begin
      tvalid_q    <= 1'b0;
      beat_q.last <= 1'b0;
    end else if (load) begin
      tvalid_q <= 1'b1;
      beat_q   <= next_beat;
    end else if (accept) begin
      tvalid_q <= 1'b0;
    end
  end

  assign M_AXIS_TVALID = tvalid_q;
  assign M_AXIS_TDATA  = beat_q.data;
  assign M_AXIS_TSTRB  = beat_q.strb;
  assign M_AXIS_TLAST  = beat_q.last;

  // stalled beat holds until taken.
  a_hold_stable: assert property (@(posedge M_AXIS_ACLK) disable iff (!M_AXIS_ARESETN)
    (M_AXIS_TVALID && !M_AXIS_TREADY) |=>
      (M_AXIS_TVALID && $stable(M_AXIS_TDATA) && $stable(M_AXIS_TLAST)))
    else $error("axis_burst_gen: beat changed while stalled");

  a_valid_in_send: assert property (@(posedge M_AXIS_ACLK) disable iff (!M_AXIS_ARESETN)
    M_AXIS_TVALID |-> (state_q == SEND_STREAM))
    else $error("axis_burst_gen: TVALID high outside SEND_STREAM");

endmodule

// ==== design/axis_pattern_top.sv ====
`include "stream_consts.svh"

module axis_pattern_top (
  input  logic                        M_AXIS_ACLK,
  input  logic                        M_AXIS_ARESETN,
  input  gen_cfg_pkg::host_req_t      host_req,
  output logic [31:0]                 rdata,
  output logic                        rvalid,
  output logic                        M_AXIS_TVALID,
  output logic [`STREAM_DATA_W-1:0]   M_AXIS_TDATA,
  output logic [`STREAM_STRB_W-1:0]   M_AXIS_TSTRB,
  output logic                        M_AXIS_TLAST,
  input  logic                        M_AXIS_TREADY
);
  import gen_cfg_pkg::*;

  gen_cfg_t cfg;
  logic     burst_done;

  // ********************
  // host registers.
  pattern_regs regs_i (
    .M_AXIS_ACLK    (M_AXIS_ACLK),
    .M_AXIS_ARESETN (M_AXIS_ARESETN),
    .host_req       (host_req),
    .rdata          (rdata),
    .rvalid         (rvalid),
    .burst_done     (burst_done),
    .cfg            (cfg)
  );

  // ********************
  // stream source.
  axis_burst_gen gen_i (
    .M_AXIS_ACLK    (M_AXIS_ACLK),
    .M_AXIS_ARESETN (M_AXIS_ARESETN),
    .cfg            (cfg),
    .burst_done     (burst_done),
    .M_AXIS_TVALID  (M_AXIS_TVALID),
    .M_AXIS_TDATA   (M_AXIS_TDATA),
    .M_AXIS_TSTRB   (M_AXIS_TSTRB),
    .M_AXIS_TLAST   (M_AXIS_TLAST),
    .M_AXIS_TREADY  (M_AXIS_TREADY)
  );

endmodule

// ==== tb/axis_pattern_tb.sv ====
`include "stream_consts.svh"

module axis_pattern_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import axis_pkg::*;
  import gen_cfg_pkg::*;

  // beats of all tests plus delays and the two reset phases.
  localparam int total_beats = 31;
  localparam int total_delay = 4 + 2 + 3 * 3 + 0;
  localparam int watchdog_cycles = total_beats * 40 + total_delay + 2 * 16 + 200;

  logic                      M_AXIS_ACLK;
  logic                      M_AXIS_ARESETN;
  host_req_t                 host_req;
  logic [31:0]               rdata;
  logic                      rvalid;
  logic                      M_AXIS_TVALID;
  logic [`STREAM_DATA_W-1:0] M_AXIS_TDATA;
  logic [`STREAM_STRB_W-1:0] M_AXIS_TSTRB;
  logic                      M_AXIS_TLAST;
  logic                      M_AXIS_TREADY;

  axis_beat_t  beats[$];
  axis_beat_t  held_beat;
  logic        stalled = 1'b0;
  logic [31:0] rng = 32'h9296_43b4;
  logic        ready_random = 1'b0;
  int          errors = 0;
  int          checks = 0;
  int          latency;

  axis_pattern_top dut_i (
    .M_AXIS_ACLK    (M_AXIS_ACLK),
    .M_AXIS_ARESETN (M_AXIS_ARESETN),
    .host_req       (host_req),
    .rdata          (rdata),
    .rvalid         (rvalid),
    .M_AXIS_TVALID  (M_AXIS_TVALID),
    .M_AXIS_TDATA   (M_AXIS_TDATA),
    .M_AXIS_TSTRB   (M_AXIS_TSTRB),
    .M_AXIS_TLAST   (M_AXIS_TLAST),
    .M_AXIS_TREADY  (M_AXIS_TREADY)
  );

  initial begin
    M_AXIS_ACLK = 1'b0;
    forever #10 M_AXIS_ACLK = ~M_AXIS_ACLK;
  end

  // accepted beats in arrival order, and a stalled beat must hold.
  always @(posedge M_AXIS_ACLK) begin
    if (!M_AXIS_ARESETN) begin
      stalled = 1'b0;
    end else begin
      if (stalled) begin
        if (M_AXIS_TVALID !== 1'b1) begin
          errors++;
          $display("TVALID dropped while a beat was stalled");
        end
        compare_beat("held beat", held_beat, {M_AXIS_TDATA, M_AXIS_TSTRB, M_AXIS_TLAST});
      end
      if (M_AXIS_TVALID && M_AXIS_TREADY) begin
        beats.push_back({M_AXIS_TDATA, M_AXIS_TSTRB, M_AXIS_TLAST});
      end
      stalled   = M_AXIS_TVALID && !M_AXIS_TREADY;
      held_beat = {M_AXIS_TDATA, M_AXIS_TSTRB, M_AXIS_TLAST};
    end
  end

  initial begin
    #(watchdog_cycles * 20);
    $display("timeout: the run did not finish within %0d cycles", watchdog_cycles);
    $display("test failed");
    $finish;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // ********************
  // advance one cycle with inputs changed on the falling edge.
  task automatic step();
    @(negedge M_AXIS_ACLK);
    if (ready_random) begin
      rng = xorshift32(rng);
      M_AXIS_TREADY = rng[4];
    end
  endtask

  task automatic apply_reset();
    M_AXIS_ARESETN = 1'b0;
    repeat (16) step();
    M_AXIS_ARESETN = 1'b1;
    step();
  endtask

  task automatic compare_beat(input string name, input axis_beat_t exp, input axis_beat_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("FAILED %s: expected data %h strb %h last %h, got data %h strb %h last %h",
               name, exp.data, exp.strb, exp.last, act.data, act.strb, act.last);
    end
  endtask

  task automatic compare_rdata(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("FAILED %s: expected %h, got %h", name, exp, act);
    end
  endtask

  task automatic compare_count(input string name, input int exp, input int act);
    checks++;
    if (exp != act) begin
      errors++;
      $display("FAILED %s: expected %h, got %h", name, exp, act);
    end
  endtask

  task automatic write_reg(input reg_addr_e addr, input logic [31:0] data);
    host_req.wr    = 1'b1;
    host_req.addr  = addr;
    host_req.wdata = data;
    step();
    host_req.wr = 1'b0;
  endtask

  task automatic read_check(input reg_addr_e addr, input logic [31:0] exp);
    host_req.rd   = 1'b1;
    host_req.addr = addr;
    step();
    host_req.rd = 1'b0;
    if (rvalid !== 1'b1) begin
      errors++;
      $display("rvalid did not pulse one cycle after a read of %s", addr.name());
    end else begin
      compare_rdata($sformatf("rdata %s", addr.name()), exp, rdata);
    end
  endtask

  task automatic wait_beats(input int n);
    int waited = 0;
    while (beats.size() < n && waited < 400) begin
      step();
      waited++;
    end
    if (beats.size() < n) begin
      errors++;
      $display("only %0d of %0d beats arrived in time", beats.size(), n);
    end
  endtask

  task automatic wait_valid();
    int waited = 0;
    while (!M_AXIS_TVALID && waited < 400) begin
      step();
      waited++;
    end
    if (!M_AXIS_TVALID) begin
      errors++;
      $display("TVALID never rose after enable");
    end
  endtask

  // beat i carries base + i and a zero length means one beat.
  task automatic check_burst(input logic [31:0] base, input logic [7:0] len, input int first);
    int         n;
    axis_beat_t exp;
    n = (len == 0) ? 1 : len;
    for (int i = 0; i < n && first + i < beats.size(); i++) begin
      exp.data = base + i;
      exp.strb = '1;
      exp.last = (i == n - 1);
      compare_beat($sformatf("beat %0d", first + i), exp, beats[first + i]);
    end
  endtask

  // enable is pulsed so that exactly one burst follows.
  task automatic run_burst(input logic [7:0] delay, input logic [7:0] len,
                           input logic [31:0] base, output int cycles);
    int n;
    n = (len == 0) ? 1 : int'(len);
    beats.delete();
    write_reg(REG_DELAY, 32'(delay));
    write_reg(REG_LEN, 32'(len));
    write_reg(REG_BASE, base);
    write_reg(REG_CTRL, 32'h1);
    write_reg(REG_CTRL, 32'h0);
    cycles = 1;
    while (!M_AXIS_TVALID && cycles < 400) begin
      step();
      cycles++;
    end
    wait_beats(n);
    check_burst(base, len, 0);
    // no beat follows the one marked last.
    repeat (4) step();
    compare_count("beats in burst", n, beats.size());
  endtask

  // ********************
  // directed tests.
  task automatic test_reset_state();
    if (M_AXIS_TVALID !== 1'b0) begin
      errors++;
      $display("TVALID is high right after reset");
    end
    read_check(REG_CTRL, 32'h0);
    read_check(REG_DELAY, 32'h0);
    read_check(REG_LEN, 32'h0);
    read_check(REG_BASE, 32'h0);
  endtask

  task automatic test_reg_readback();
    // enable starts a one beat burst that the ready sink drains.
    write_reg(REG_CTRL, 32'h1);
    read_check(REG_CTRL, 32'h1);
    write_reg(REG_CTRL, 32'h0);
    write_reg(REG_DELAY, 32'h5a);
    read_check(REG_DELAY, 32'h5a);
    write_reg(REG_LEN, 32'ha5);
    read_check(REG_LEN, 32'ha5);
  endtask

  task automatic test_repeat_bursts();
    apply_reset();
    beats.delete();
    write_reg(REG_DELAY, 32'h3);
    write_reg(REG_LEN, 32'h4);
    write_reg(REG_BASE, 32'h40);
    write_reg(REG_CTRL, 32'h1);
    wait_beats(8);
    wait_valid();
    write_reg(REG_CTRL, 32'h0);
    wait_beats(12);
    for (int b = 0; b < 3; b++) begin
      check_burst(32'h40, 8'd4, b * 4);
    end
    repeat (20) begin
      step();
      if (M_AXIS_TVALID) begin
        errors++;
        $display("TVALID rose again after enable was cleared");
      end
    end
    read_check(REG_BASE, 32'd3);
  endtask

  initial begin
    host_req       = '0;
    M_AXIS_ARESETN = 1'b0;
    M_AXIS_TREADY  = 1'b0;
    apply_reset();
    M_AXIS_TREADY = 1'b1;

    test_reset_state();
    test_reg_readback();
    repeat (4) step();

    run_burst(8'd4, 8'd5, 32'h100, latency);
    compare_count("first TVALID latency", 4 + 3, latency);

    ready_random = 1'b1;
    run_burst(8'd2, 8'd12, 32'hffff_fffa, latency);
    ready_random  = 1'b0;
    M_AXIS_TREADY = 1'b1;

    test_repeat_bursts();
    run_burst(8'd0, 8'd0, 32'hcafe_0000, latency);

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+include
design/axis_pkg.sv
design/gen_cfg_pkg.sv
design/pattern_regs.sv
design/axis_burst_gen.sv
design/axis_pattern_top.sv
tb/axis_pattern_tb.sv

// ==== Makefile ====
TOP = axis_pattern_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f verilog.f --top-module $(TOP)

# the log is searched for the pass line, so a failed or crashed run fails make.
sim:
	verilator --binary --timing --assert -j 0 -f verilog.f --top-module $(TOP) \
	  --Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "^test passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
